/* src.f */
verilog/uart_link_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/header_collector.sv
verilog/nonce_sender.sv
verilog/segment_display.sv
verilog/uart_core.sv
verif/uart_core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module uart_core_tb -f src.f \
    -o uart_core_sim || { echo "build failed"; exit 1; }
sim_output=$(./obj_dir/uart_core_sim)
echo "$sim_output"
echo "$sim_output" | grep -qx "RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verif/uart_core_tb.sv */
`timescale 1ns/10ps

module uart_core_tb;

    localparam int BIT_CYCLES  = 8;
    localparam int SCAN_CYCLES = 4;
    localparam int CLOCK_NS    = 40;
    localparam int FRAME_LIMIT = 120;
    localparam int WATCHDOG_NS = FRAME_LIMIT * 10 * BIT_CYCLES * CLOCK_NS + 200 * CLOCK_NS;

    logic        clock = 1'b0;
    logic        reset;
    logic        rxd;
    logic [31:0] nonce;
    logic        nonce_load;
    logic        transmit;
    logic        display_select;
    logic        txd;
    logic [7:0]  ca;
    logic [7:0]  an;

    int          errors = 0;
    logic [31:0] lfsr_state = 32'h3b32;
    logic [7:0]  expect_q[$];                        // nonce bytes still due on txd.
    logic        transmit_seen = 1'b0;
    logic        host_sending = 1'b0;
    logic        frame_done = 1'b0;
    logic        frame_expected = 1'b0;
    logic [9:0]  frame_bits = '1;                    // stop, data, start.
    logic [7:0]  frame_expect_byte = '0;
    logic [31:0] shown_word = '0;
    logic        shown_ok = 1'b0;
    int          sweeps = 0;
    logic        display_check = 1'b0;
    logic [31:0] display_expect = '0;
    string       display_what = "";

    uart_core #(.CLOCKS_PER_BIT(BIT_CYCLES), .SCAN_CYCLES(SCAN_CYCLES)) i_uart_core (
        .clock(clock), .reset(reset), .rxd(rxd), .nonce(nonce), .nonce_load(nonce_load),
        .transmit(transmit), .display_select(display_select), .txd(txd), .ca(ca), .an(an)
    );

    always #(CLOCK_NS / 2) clock = ~clock;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {1'b0, state[31:1]} ^ (state[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // bit 4 flags a glyph that matched one of the sixteen
    function automatic logic [4:0] segments_to_hex(input logic [7:0] segments);
        logic [4:0] result;
        int d;
        result = 5'h0;
        for (d = 0; d < 16; d++) begin
            if (uart_link_pkg::hex_to_segments(4'(d)) == segments) begin
                result = {1'b1, 4'(d)};
            end
        end
        return result;
    endfunction

    function automatic int lit_digit(input logic [7:0] anodes);
        int found;
        int i;
        found = -1;
        for (i = 0; i < 8; i++) begin
            if (anodes == ~(8'h01 << i)) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        int b;
        frame = {stop_bit, data, 1'b0};
        @(posedge clock);
        #2;
        host_sending = 1'b1;
        for (b = 0; b < 10; b++) begin
            rxd = frame[b];
            repeat (BIT_CYCLES) @(posedge clock);
            #2;
        end
        rxd = 1'b1;
        host_sending = 1'b0;
        repeat (BIT_CYCLES) @(posedge clock);        // one idle bit between frames.
    endtask

    task automatic load_nonce(input logic [31:0] value);
        @(posedge clock);
        #2;
        nonce = value;
        nonce_load = 1'b1;
        expect_q.push_back(value[31:24]);
        expect_q.push_back(value[23:16]);
        expect_q.push_back(value[15:8]);
        expect_q.push_back(value[7:0]);
        @(posedge clock);
        #2;
        nonce_load = 1'b0;
    endtask

    task automatic pulse_transmit();
        @(posedge clock);
        #2;
        transmit = 1'b1;
        transmit_seen = 1'b1;
        @(posedge clock);
        #2;
        transmit = 1'b0;
    endtask

    task automatic wait_nonce_sent();
        while (expect_q.size() != 0) @(negedge clock);
    endtask

    task automatic check_display(input logic select, input logic [31:0] word, input string what);
        int start;
        @(posedge clock);
        #2;
        display_select = select;
        start = sweeps;
        wait (sweeps >= start + 2);                  // the second sweep is all new digits.
        @(negedge clock);
        display_expect = word;
        display_what = what;
        display_check = 1'b1;
        @(negedge clock);
        display_check = 1'b0;
    endtask

    // the start is seen half a cycle in, so centres land 3.5 cycles into each bit
    initial begin : capture_frames
        int b;
        forever begin
            @(negedge clock);
            frame_done = 1'b0;
            if (!reset && !txd) begin
                repeat (BIT_CYCLES / 2 - 1) @(negedge clock);
                frame_bits[0] = txd;
                for (b = 1; b < 10; b++) begin
                    repeat (BIT_CYCLES) @(negedge clock);
                    frame_bits[b] = txd;
                end
                frame_expected = (expect_q.size() != 0);
                if (frame_expected) begin
                    frame_expect_byte = expect_q.pop_front();
                end
                frame_done = 1'b1;
            end
        end
    end

    initial begin : decode_display
        logic [7:0]  an_last;
        logic [31:0] build;
        logic        build_ok;
        logic [4:0]  decoded;
        int          index;
        an_last = 8'hff;
        build = '0;
        build_ok = 1'b1;
        forever begin
            @(negedge clock);
            if (an != an_last) begin
                an_last = an;
                index = lit_digit(an);
                decoded = segments_to_hex(ca);
                if (index < 0) begin
                    build_ok = 1'b0;
                end else begin
                    if (index == 0) begin
                        build_ok = 1'b1;             // a new sweep starts.
                    end
                    build[index*4 +: 4] = decoded[3:0];
                    build_ok = build_ok && decoded[4];
                    if (index == 7) begin
                        shown_word = build;
                        shown_ok = build_ok;
                        sweeps = sweeps + 1;
                    end
                end
            end
        end
    end

    idle_until_transmit: assert property (@(posedge clock) disable iff (reset)
        !transmit_seen |-> txd)
        else begin
            errors = errors + 1;
            $display("Fail %0t: txd left idle before any transmit request", $time);
        end

    frame_shape: assert property (@(posedge clock) disable iff (reset)
        frame_done |-> (!frame_bits[0] && frame_bits[9]))
        else begin
            errors = errors + 1;
            $display("Fail %0t: txd frame %b has a bad start or stop bit", $time, frame_bits);
        end

    frame_wanted: assert property (@(posedge clock) disable iff (reset)
        frame_done |-> frame_expected)
        else begin
            errors = errors + 1;
            $display("an extra frame appeared on txd at %0t", $time);
        end

    frame_data: assert property (@(posedge clock) disable iff (reset)
        (frame_done && frame_expected) |-> (frame_bits[8:1] == frame_expect_byte))
        else begin
            errors = errors + 1;
            $display("Fail %0t: txd byte %h, expected %h", $time, frame_bits[8:1],
                     frame_expect_byte);
        end

    receive_interlock: assert property (@(posedge clock) disable iff (reset)
        host_sending |-> txd)
        else begin
            errors = errors + 1;
            $display("Fail %0t: txd started while a receive frame was in progress", $time);
        end

    display_word: assert property (@(posedge clock) disable iff (reset)
        display_check |-> (shown_ok && shown_word == display_expect))
        else begin
            errors = errors + 1;
            $display("Fail %0t: %s display shows %h, expected %h", $time, display_what,
                     shown_word, display_expect);
        end

    initial begin : run_tests
        logic [31:0] bits;
        logic [31:0] first_word;
        logic [15:0] good_count;
        logic [15:0] bad_count;
        int          i;
        reset = 1'b1;
        rxd = 1'b1;
        nonce = '0;
        nonce_load = 1'b0;
        transmit = 1'b0;
        display_select = 1'b0;
        first_word = '0;
        good_count = '0;
        bad_count = '0;
        repeat (16) @(posedge clock);
        #2;
        reset = 1'b0;
        repeat (40) @(posedge clock);                // line must stay idle here.

        take_bits(32, bits);
        load_nonce(bits);
        pulse_transmit();
        wait_nonce_sent();

        for (i = 0; i < 80; i++) begin
            if (i == 40) begin
                take_bits(8, bits);
                send_frame(bits[7:0], 1'b0);         // framing error mid stream.
                bad_count = bad_count + 16'd1;
            end
            take_bits(8, bits);
            if (i < 4) begin
                first_word = {first_word[23:0], bits[7:0]};
            end
            send_frame(bits[7:0], 1'b1);
            good_count = good_count + 16'd1;
        end
        check_display(1'b1, first_word, "header");
        check_display(1'b0, {bad_count, good_count}, "counter");

        take_bits(32, bits);
        load_nonce(bits);
        take_bits(8, bits);
        fork
            send_frame(bits[7:0], 1'b1);
            begin
                repeat (3 * BIT_CYCLES) @(posedge clock);
                pulse_transmit();
            end
        join
        good_count = good_count + 16'd1;
        wait_nonce_sent();
        check_display(1'b0, {bad_count, good_count}, "counter");
        repeat (2 * BIT_CYCLES) @(posedge clock);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("errors: %0d", errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* verilog/uart_core.sv */
`timescale 1ns/10ps

module uart_core #(
    parameter int CLOCKS_PER_BIT = uart_link_pkg::DEFAULT_CLOCKS_PER_BIT,
    parameter int SCAN_CYCLES    = uart_link_pkg::DEFAULT_SCAN_CYCLES
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 rxd,
    input  uart_link_pkg::word_t nonce,
    input  logic                 nonce_load,
    input  logic                 transmit,
    input  logic                 display_select,
    output logic                 txd,
    output logic [7:0]           ca,
    output logic [7:0]           an
);

    uart_link_pkg::byte_t  rx_data;
    logic                  rx_valid;
    logic                  rx_error;
    logic                  rx_ready;
    logic                  rx_busy;
    uart_link_pkg::byte_t  tx_data;
    logic                  tx_valid;
    logic                  tx_ready;
    uart_link_pkg::word_t  header_top;
    uart_link_pkg::count_t byte_count;
    uart_link_pkg::count_t error_count;

    uart_rx #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) i_uart_rx (
        .clock(clock), .reset(reset), .rxd(rxd),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_error(rx_error),
        .rx_busy(rx_busy), .rx_ready(rx_ready)
    );

    header_collector i_header_collector (
        .clock(clock), .reset(reset),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_error(rx_error), .rx_ready(rx_ready),
        .header_top(header_top), .byte_count(byte_count), .error_count(error_count)
    );

    nonce_sender i_nonce_sender (
        .clock(clock), .reset(reset),
        .nonce(nonce), .nonce_load(nonce_load), .transmit(transmit), .rx_busy(rx_busy),
        .tx_ready(tx_ready), .tx_data(tx_data), .tx_valid(tx_valid)
    );

    uart_tx #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) i_uart_tx (
        .clock(clock), .reset(reset),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready), .txd(txd)
    );

    segment_display #(.SCAN_CYCLES(SCAN_CYCLES)) i_segment_display (
        .clock(clock), .reset(reset), .display_select(display_select),
        .header_top(header_top), .byte_count(byte_count), .error_count(error_count),
        .ca(ca), .an(an)
    );

endmodule

/* verilog/segment_display.sv */
`timescale 1ns/10ps

module segment_display #(
    parameter int SCAN_CYCLES = uart_link_pkg::DEFAULT_SCAN_CYCLES
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  display_select,
    input  uart_link_pkg::word_t  header_top,
    input  uart_link_pkg::count_t byte_count,
    input  uart_link_pkg::count_t error_count,
    output logic [7:0]            ca,
    output logic [7:0]            an
);

    localparam int SCAN_WIDTH = $clog2(SCAN_CYCLES + 1);
    localparam logic [SCAN_WIDTH-1:0] LAST_SCAN = SCAN_WIDTH'(SCAN_CYCLES - 1);

    uart_link_pkg::word_t  display_word;
    logic [SCAN_WIDTH-1:0] scan_count;
    logic [2:0]            digit;
    logic [3:0]            nibble;

    assign display_word = display_select ? header_top : {error_count, byte_count};
    assign nibble       = display_word[{digit, 2'b00} +: 4];

    // digit i lights nibble i, both registered on the same step
    always_ff @(posedge clock) begin
        if (reset) begin
            scan_count <= '0;
            digit      <= '0;
            an         <= 8'hff;                      // all dark until the first step.
            ca         <= 8'hff;
        end else if (scan_count == LAST_SCAN) begin
            scan_count <= '0;
            digit      <= digit + 1'b1;               // wraps from 7 back to 0.
            an         <= ~(8'h01 << digit);
            ca         <= uart_link_pkg::hex_to_segments(nibble);
        end else begin
            scan_count <= scan_count + 1'b1;
        end
    end

endmodule

/* verilog/nonce_sender.sv */
`timescale 1ns/10ps

module nonce_sender (
    input  logic                 clock,
    input  logic                 reset,
    input  uart_link_pkg::word_t nonce,
    input  logic                 nonce_load,
    input  logic                 transmit,
    input  logic                 rx_busy,
    input  logic                 tx_ready,
    output uart_link_pkg::byte_t tx_data,
    output logic                 tx_valid
);

    localparam int BYTE_BITS   = $bits(uart_link_pkg::byte_t);
    localparam int WORD_BITS   = $bits(uart_link_pkg::word_t);
    localparam int INDEX_WIDTH = $clog2(uart_link_pkg::NONCE_BYTES);
    localparam logic [INDEX_WIDTH-1:0] LAST_BYTE = INDEX_WIDTH'(uart_link_pkg::NONCE_BYTES - 1);

    uart_link_pkg::word_t   nonce_hold;
    logic                   pending;
    logic [INDEX_WIDTH-1:0] byte_index;
    logic                   accepted;

    assign accepted = tx_valid && tx_ready;
    assign tx_data  = nonce_hold[WORD_BITS-1 -: BYTE_BITS];  // msb byte goes first.

    // a load during a transfer would corrupt the bytes still to go
    always_ff @(posedge clock) begin
        if (nonce_load && !pending) begin
            nonce_hold <= nonce;
        end else if (accepted) begin
            nonce_hold <= {nonce_hold[WORD_BITS-BYTE_BITS-1:0], {BYTE_BITS{1'b0}}};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pending    <= 1'b0;
            tx_valid   <= 1'b0;
            byte_index <= '0;
        end else begin
            if (accepted) begin
                tx_valid   <= 1'b0;
                byte_index <= byte_index + 1'b1;
                if (byte_index == LAST_BYTE) begin
                    pending <= 1'b0;
                end
            end else if (pending && !tx_valid && !rx_busy) begin
                tx_valid <= 1'b1;                     // never start during a receive.
            end else if (transmit && !pending) begin
                pending    <= 1'b1;                   // request while pending is dropped.
                byte_index <= '0;
            end
        end
    end

    tx_data_held: assert property (@(posedge clock) disable iff (reset)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)))
        else $error("Fail %0t: tx byte changed or withdrawn before acceptance", $time);

endmodule

/* verilog/header_collector.sv */
`timescale 1ns/10ps

module header_collector (
    input  logic                  clock,
    input  logic                  reset,
    input  uart_link_pkg::byte_t  rx_data,
    input  logic                  rx_valid,
    input  logic                  rx_error,
    output logic                  rx_ready,
    output uart_link_pkg::word_t  header_top,
    output uart_link_pkg::count_t byte_count,
    output uart_link_pkg::count_t error_count
);

    localparam int BYTE_BITS   = $bits(uart_link_pkg::byte_t);
    localparam int WORD_BITS   = $bits(uart_link_pkg::word_t);
    localparam int HEADER_BITS = uart_link_pkg::HEADER_BYTES * BYTE_BITS;

    logic [HEADER_BITS-1:0] header;
    logic                   take;

    assign rx_ready   = 1'b1;                         // receiver has no buffer.
    assign take       = rx_valid && rx_ready;
    assign header_top = header[HEADER_BITS-1 -: WORD_BITS];

    // oldest of the last 80 good bytes ends up at the top
    always_ff @(posedge clock) begin
        if (reset) begin
            header <= '0;
        end else if (take && !rx_error) begin
            header <= {header[HEADER_BITS-BYTE_BITS-1:0], rx_data};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            byte_count  <= '0;
            error_count <= '0;
        end else if (take) begin
            if (rx_error) begin
                error_count <= error_count + 1'b1;    // wraps.
            end else begin
                byte_count <= byte_count + 1'b1;
            end
        end
    end

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx #(
    parameter int CLOCKS_PER_BIT = uart_link_pkg::DEFAULT_CLOCKS_PER_BIT
) (
    input  logic                 clock,
    input  logic                 reset,
    input  uart_link_pkg::byte_t tx_data,
    input  logic                 tx_valid,
    output logic                 tx_ready,
    output logic                 txd
);

    localparam int TIMER_WIDTH = $clog2(CLOCKS_PER_BIT + 1);
    localparam logic [TIMER_WIDTH-1:0] LAST_TICK = TIMER_WIDTH'(CLOCKS_PER_BIT - 1);

    logic [9:0]             frame;
    logic                   busy;
    logic [TIMER_WIDTH-1:0] bit_timer;
    logic [3:0]             bit_index;
    logic                   bit_done;
    logic                   frame_done;

    assign bit_done   = (bit_timer == LAST_TICK);
    assign frame_done = bit_done && (bit_index == 4'd9);  // last tick of the stop bit.
    assign tx_ready   = !busy || frame_done;
    assign txd        = frame[0];

    always_ff @(posedge clock) begin
        if (reset) begin
            frame     <= '1;
            busy      <= 1'b0;
            bit_timer <= '0;
            bit_index <= '0;
        end else if (tx_valid && tx_ready) begin
            frame     <= {1'b1, tx_data, 1'b0};       // stop, data, start.
            busy      <= 1'b1;
            bit_timer <= '0;
            bit_index <= '0;
        end else if (busy) begin
            if (bit_done) begin
                bit_timer <= '0;
                bit_index <= bit_index + 1'b1;
                frame     <= {1'b1, frame[9:1]};      // refill with idle level.
                if (frame_done) begin
                    busy <= 1'b0;
                end
            end else begin
                bit_timer <= bit_timer + 1'b1;
            end
        end
    end

    // the line must rest high whenever no frame is in flight
    idle_line_high: assert property (@(posedge clock) disable iff (reset)
        !busy |-> txd)
        else $error("Fail %0t: txd low while transmitter idle", $time);

endmodule

/* verilog/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
    parameter int CLOCKS_PER_BIT = uart_link_pkg::DEFAULT_CLOCKS_PER_BIT
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 rxd,
    output uart_link_pkg::byte_t rx_data,
    output logic                 rx_valid,
    output logic                 rx_error,
    output logic                 rx_busy,
    input  logic                 rx_ready
);

    localparam int TIMER_WIDTH = $clog2(CLOCKS_PER_BIT + 1);
    localparam logic [TIMER_WIDTH-1:0] LAST_TICK = TIMER_WIDTH'(CLOCKS_PER_BIT - 1);
    localparam logic [TIMER_WIDTH-1:0] HALF_TICK = TIMER_WIDTH'(CLOCKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t                 state;
    logic [TIMER_WIDTH-1:0] bit_timer;
    logic [2:0]             bit_index;
    logic                   rxd_meta;
    logic                   rxd_sync;
    logic                   rxd_last;
    logic                   bit_end;

    assign bit_end = (bit_timer == LAST_TICK);
    assign rx_busy = (state != IDLE) || rx_valid;     // covers the result pulse too.

    always_ff @(posedge clock) begin
        if (reset) begin
            rxd_meta <= 1'b1;                         // line idles high.
            rxd_sync <= 1'b1;
            rxd_last <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_last <= rxd_sync;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= IDLE;
            bit_timer <= '0;
            bit_index <= '0;
            rx_valid  <= 1'b0;
            rx_error  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                IDLE: begin
                    bit_timer <= '0;
                    bit_index <= '0;
                    if (rxd_last && !rxd_sync) begin
                        state <= START;               // falling edge.
                    end
                end
                START: begin
                    if (bit_timer == HALF_TICK) begin
                        bit_timer <= '0;
                        state     <= rxd_sync ? IDLE : DATA;  // glitch goes back to idle.
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        bit_timer <= '0;
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7) begin
                            state <= STOP;
                        end
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        rx_valid <= 1'b1;
                        rx_error <= !rxd_sync;        // stop bit must be high.
                        state    <= IDLE;
                    end else begin
                        bit_timer <= bit_timer + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == DATA && bit_end) begin
            rx_data <= {rxd_sync, rx_data[7:1]};      // lsb arrives first.
        end
    end

    rx_ready_held: assert property (@(posedge clock) disable iff (reset)
        rx_valid |-> rx_ready)
        else $error("Fail %0t: rx_valid high while rx_ready low", $time);

endmodule

/* verilog/uart_link_pkg.sv */
package uart_link_pkg;

    typedef logic [7:0]  byte_t;                  // one serial data byte.
    typedef logic [15:0] count_t;
    typedef logic [31:0] word_t;

    localparam int DEFAULT_CLOCKS_PER_BIT = 434;  // 115200 baud from 50 MHz.
    localparam int HEADER_BYTES = 80;
    localparam int NONCE_BYTES = 4;
    localparam int DEFAULT_SCAN_CYCLES = 1024;

    // active low, a..g in bits 0..6, dp in bit 7 kept dark
    function automatic logic [7:0] hex_to_segments(input logic [3:0] digit);
        logic [7:0] segments;
        case (digit)
            4'h0:    segments = 8'hc0;
            4'h1:    segments = 8'hf9;
            4'h2:    segments = 8'ha4;
            4'h3:    segments = 8'hb0;
            4'h4:    segments = 8'h99;
            4'h5:    segments = 8'h92;
            4'h6:    segments = 8'h82;
            4'h7:    segments = 8'hf8;
            4'h8:    segments = 8'h80;
            4'h9:    segments = 8'h90;
            4'ha:    segments = 8'h88;
            4'hb:    segments = 8'h83;
            4'hc:    segments = 8'hc6;
            4'hd:    segments = 8'ha1;
            4'he:    segments = 8'h86;
            default: segments = 8'h8e;            // f.
        endcase
        return segments;
    endfunction

endpackage
